//--- exe_cfg.svh
`ifndef EXE_CFG_SVH
`define EXE_CFG_SVH

// data path width of the RV64I core.
`define EXE_XLEN 64

// instruction word width.
`define EXE_ILEN 32

// shift amount widths for double-word and word operations.
`define EXE_SHAMT 6
`define EXE_SHAMTW 5

`endif

//--- exe_pkg.sv
`include "exe_cfg.svh"

package exe_pkg;

    typedef logic [`EXE_XLEN-1:0] xlenT;
    typedef logic [`EXE_ILEN-1:0] instrT;

    // ***********************************************************
    // bit 4 word mode, bit 3 alternate form, bits 2..0 function.
    // ***********************************************************
    typedef enum logic [4:0] {
        aluAdd   = 5'b00000,
        aluSll   = 5'b00001,
        aluSltu  = 5'b00010,
        aluPassB = 5'b00011,
        aluXor   = 5'b00100,
        aluSrl   = 5'b00101,
        aluOr    = 5'b00110,
        aluAnd   = 5'b00111,
        aluSub   = 5'b01000,
        aluSlt   = 5'b01010,
        aluSra   = 5'b01101,
        aluAddw  = 5'b10000,
        aluSllw  = 5'b10001,
        aluSrlw  = 5'b10101,
        aluSubw  = 5'b11000,
        aluSraw  = 5'b11101
    } aluOpT;

    typedef enum logic {
        srcARs1 = 1'b0,
        srcAPc  = 1'b1
    } srcASelT;

    typedef enum logic [1:0] {
        srcBRs2  = 2'd0,
        srcBImm  = 2'd1,
        srcBFour = 2'd2
    } srcBSelT;

    typedef enum logic [2:0] {
        immI, immS, immB, immU, immJ
    } immFmtT;

    // jal and jalr are listed with the branches since they share the target path.
    typedef enum logic [3:0] {
        brNone, brEq, brNe, brLt, brGe, brLtu, brGeu, brJal, brJalr
    } branchOpT;

endpackage

//--- exeDecode.sv
`timescale 1ns/1ns

module exeDecode (
    input  exe_pkg::instrT    instr,
    output exe_pkg::aluOpT    aluOp,
    output exe_pkg::srcASelT  srcASel,
    output exe_pkg::srcBSelT  srcBSel,
    output exe_pkg::immFmtT   immFmt,
    output exe_pkg::branchOpT branchOp,
    output logic              writeEn,
    output logic              illegal,
    output logic [4:0]        rdAddr
);

    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opImm32  = 7'b0011011;
    localparam logic [6:0] opOp32   = 7'b0111011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       baseF7; // funct7 all zero.
    logic       altF7;  // funct7 selecting sub or sra.
    logic       shiftOk; // upper six bits of a 64-bit immediate shift.

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign baseF7  = (funct7 == 7'b0000000);
    assign altF7   = (funct7 == 7'b0100000);
    assign shiftOk = (instr[31:26] == 6'b000000) ||
                     (funct3 == 3'b101 && instr[31:26] == 6'b010000);
    assign rdAddr  = instr[11:7];

    always_comb begin
        aluOp    = exe_pkg::aluAdd;
        srcASel  = exe_pkg::srcARs1;
        srcBSel  = exe_pkg::srcBRs2;
        immFmt   = exe_pkg::immI;
        branchOp = exe_pkg::brNone;
        writeEn  = 1'b1;
        illegal  = 1'b0;
        case (opcode)
            opOp, opImm: begin
                if (opcode == opImm) begin
                    srcBSel = exe_pkg::srcBImm;
                end
                case (funct3)
                    3'b000: aluOp = (opcode == opOp && altF7) ? exe_pkg::aluSub
                                                              : exe_pkg::aluAdd;
                    3'b001: aluOp = exe_pkg::aluSll;
                    3'b010: aluOp = exe_pkg::aluSlt;
                    3'b011: aluOp = exe_pkg::aluSltu;
                    3'b100: aluOp = exe_pkg::aluXor;
                    3'b101: aluOp = instr[30] ? exe_pkg::aluSra : exe_pkg::aluSrl;
                    3'b110: aluOp = exe_pkg::aluOr;
                    default: aluOp = exe_pkg::aluAnd;
                endcase
                if (opcode == opOp) begin
                    illegal = !(baseF7 || (altF7 && (funct3 == 3'b000 || funct3 == 3'b101)));
                end else if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    illegal = !shiftOk;
                end
            end
            opOp32, opImm32: begin
                if (opcode == opImm32) begin
                    srcBSel = exe_pkg::srcBImm;
                end
                case (funct3)
                    3'b000: begin
                        aluOp   = (opcode == opOp32 && altF7) ? exe_pkg::aluSubw
                                                              : exe_pkg::aluAddw;
                        illegal = (opcode == opOp32) && !(baseF7 || altF7);
                    end
                    3'b001: begin
                        aluOp   = exe_pkg::aluSllw;
                        illegal = !baseF7;
                    end
                    3'b101: begin
                        aluOp   = altF7 ? exe_pkg::aluSraw : exe_pkg::aluSrlw;
                        illegal = !(baseF7 || altF7);
                    end
                    default: illegal = 1'b1;
                endcase
            end
            opLui: begin
                aluOp   = exe_pkg::aluPassB;
                srcBSel = exe_pkg::srcBImm;
                immFmt  = exe_pkg::immU;
            end
            opAuipc: begin
                srcASel = exe_pkg::srcAPc;
                srcBSel = exe_pkg::srcBImm;
                immFmt  = exe_pkg::immU;
            end
            opJal, opJalr: begin // link value is pc plus four.
                srcASel  = exe_pkg::srcAPc;
                srcBSel  = exe_pkg::srcBFour;
                immFmt   = (opcode == opJal) ? exe_pkg::immJ : exe_pkg::immI;
                branchOp = (opcode == opJal) ? exe_pkg::brJal : exe_pkg::brJalr;
                illegal  = (opcode == opJalr) && (funct3 != 3'b000);
            end
            opBranch: begin
                immFmt  = exe_pkg::immB;
                writeEn = 1'b0;
                case (funct3)
                    3'b000: begin
                        aluOp    = exe_pkg::aluSub;
                        branchOp = exe_pkg::brEq;
                    end
                    3'b001: begin
                        aluOp    = exe_pkg::aluSub;
                        branchOp = exe_pkg::brNe;
                    end
                    3'b100: begin
                        aluOp    = exe_pkg::aluSlt;
                        branchOp = exe_pkg::brLt;
                    end
                    3'b101: begin
                        aluOp    = exe_pkg::aluSlt;
                        branchOp = exe_pkg::brGe;
                    end
                    3'b110: begin
                        aluOp    = exe_pkg::aluSltu;
                        branchOp = exe_pkg::brLtu;
                    end
                    3'b111: begin
                        aluOp    = exe_pkg::aluSltu;
                        branchOp = exe_pkg::brGeu;
                    end
                    default: illegal = 1'b1;
                endcase
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) begin
            writeEn  = 1'b0;
            branchOp = exe_pkg::brNone; // an illegal word never redirects.
        end
    end

endmodule

//--- immGen.sv
`timescale 1ns/1ns

`include "exe_cfg.svh"

module immGen (
    input  exe_pkg::instrT instr,
    input  exe_pkg::immFmtT immFmt,
    output exe_pkg::xlenT  imm
);

    logic signBit;

    assign signBit = instr[31]; // every format takes its sign from bit 31.

    always_comb begin
        case (immFmt)
            exe_pkg::immS: begin
                imm = {{(`EXE_XLEN-12){signBit}}, instr[31:25], instr[11:7]};
            end
            exe_pkg::immB: begin
                imm = {{(`EXE_XLEN-12){signBit}}, instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            exe_pkg::immU: begin
                imm = {{(`EXE_XLEN-32){signBit}}, instr[31:12], 12'b0};
            end
            exe_pkg::immJ: begin
                imm = {{(`EXE_XLEN-20){signBit}}, instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: begin
                imm = {{(`EXE_XLEN-12){signBit}}, instr[31:20]};
            end
        endcase
    end

endmodule

//--- aluAdder.sv
`timescale 1ns/1ns

`include "exe_cfg.svh"

module aluAdder (
    input  exe_pkg::xlenT x,
    input  exe_pkg::xlenT y,
    input  logic          sub,
    output exe_pkg::xlenT sum,
    output logic          carry,
    output logic          zero,
    output logic          sign,
    output logic          overflow
);

    exe_pkg::xlenT yEff;
    logic          carryTop; // carry into the top bit.
    logic          carryOut;

    assign yEff = sub ? ~y : y; // the plus one enters as the low carry.

    // the sum is split so the carry into the top bit is visible.
    always_comb begin
        {carryTop, sum[`EXE_XLEN-2:0]} = {1'b0, x[`EXE_XLEN-2:0]} +
                                          {1'b0, yEff[`EXE_XLEN-2:0]} +
                                          {{(`EXE_XLEN-1){1'b0}}, sub};
        {carryOut, sum[`EXE_XLEN-1]} = {1'b0, x[`EXE_XLEN-1]} +
                                        {1'b0, yEff[`EXE_XLEN-1]} +
                                        {1'b0, carryTop};
    end

    assign overflow = carryOut ^ carryTop;
    assign carry    = carryOut ^ sub; // set means borrow when subtracting.
    assign zero     = ~|sum;
    assign sign     = sum[`EXE_XLEN-1];

endmodule

//--- alu.sv
`timescale 1ns/1ns

`include "exe_cfg.svh"

module alu (
    input  exe_pkg::xlenT  opA,
    input  exe_pkg::xlenT  opB,
    input  exe_pkg::aluOpT aluOp,
    output exe_pkg::xlenT  result,
    output logic           zero
);

    localparam int wordW = `EXE_XLEN / 2;

    logic                  wordMode;
    logic                  alt;
    logic [2:0]            func;
    logic                  sub;
    exe_pkg::xlenT         opAExt;
    exe_pkg::xlenT         opAShr; // operand for right shifts.
    exe_pkg::xlenT         opBExt;
    logic [`EXE_SHAMT-1:0] shamt;
    exe_pkg::xlenT         sum;
    exe_pkg::xlenT         rawResult;
    logic                  carry;
    logic                  sign;
    logic                  overflow;

    assign wordMode = aluOp[4];
    assign alt      = aluOp[3];
    assign func     = aluOp[2:0];
    assign sub      = alt || (func == 3'd2); // compares always subtract.

    // ***********************************************************
    // word-mode operand forming.
    // ***********************************************************
    assign opAExt = wordMode ? {{wordW{opA[wordW-1]}}, opA[wordW-1:0]} : opA;
    assign opAShr = wordMode ? {{wordW{opA[wordW-1] & alt}}, opA[wordW-1:0]} : opA;
    assign opBExt = wordMode ? {{wordW{opB[wordW-1]}}, opB[wordW-1:0]} : opB;
    assign shamt  = wordMode ? {{(`EXE_SHAMT-`EXE_SHAMTW){1'b0}}, opB[`EXE_SHAMTW-1:0]}
                             : opB[`EXE_SHAMT-1:0];

    aluAdder adder (
        .x        (opAExt),
        .y        (opBExt),
        .sub      (sub),
        .sum      (sum),
        .carry    (carry),
        .zero     (zero),
        .sign     (sign),
        .overflow (overflow)
    );

    always_comb begin
        case (func)
            3'd0: rawResult = sum;
            3'd1: rawResult = opAExt << shamt;
            3'd2: rawResult = {{(`EXE_XLEN-1){1'b0}}, alt ? (sign ^ overflow) : carry};
            3'd3: rawResult = opBExt;
            3'd4: rawResult = opAExt ^ opBExt;
            3'd5: begin
                if (alt) begin
                    rawResult = $signed(opAShr) >>> shamt;
                end else begin
                    rawResult = opAShr >> shamt;
                end
            end
            3'd6: rawResult = opAExt | opBExt;
            default: rawResult = opAExt & opBExt;
        endcase
    end

    // word results are sign-extended from bit 31.
    assign result = wordMode ? {{wordW{rawResult[wordW-1]}}, rawResult[wordW-1:0]}
                             : rawResult;

endmodule

//--- branchUnit.sv
`timescale 1ns/1ns

`include "exe_cfg.svh"

module branchUnit (
    input  exe_pkg::branchOpT branchOp,
    input  logic              zero,
    input  logic              less,
    input  exe_pkg::xlenT     pc,
    input  exe_pkg::xlenT     rs1Data,
    input  exe_pkg::xlenT     imm,
    output logic              taken,
    output exe_pkg::xlenT     target
);

    logic          isJalr;
    exe_pkg::xlenT base;
    exe_pkg::xlenT targetSum;

    // the ALU already ran sub, slt or sltu, so signed and unsigned share less.
    always_comb begin
        case (branchOp)
            exe_pkg::brEq:   taken = zero;
            exe_pkg::brNe:   taken = ~zero;
            exe_pkg::brLt:   taken = less;
            exe_pkg::brGe:   taken = ~less;
            exe_pkg::brLtu:  taken = less;
            exe_pkg::brGeu:  taken = ~less;
            exe_pkg::brJal:  taken = 1'b1;
            exe_pkg::brJalr: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    // ***********************************************************
    // target adder.
    // ***********************************************************
    assign isJalr    = (branchOp == exe_pkg::brJalr);
    assign base      = isJalr ? rs1Data : pc;
    assign targetSum = base + imm;

    assign target = isJalr ? {targetSum[`EXE_XLEN-1:1], 1'b0} : targetSum;

endmodule

//--- exeUnit.sv
`timescale 1ns/1ns

module exeUnit (
    input  logic           clk,
    input  logic           rstN,
    input  logic           inValid,
    input  exe_pkg::instrT instr,
    input  exe_pkg::xlenT  pc,
    input  exe_pkg::xlenT  rs1Data,
    input  exe_pkg::xlenT  rs2Data,
    output logic           outValid,
    output exe_pkg::xlenT  result,
    output logic [4:0]     rdAddr,
    output logic           writeEn,
    output logic           branchTaken,
    output exe_pkg::xlenT  target,
    output logic           illegal
);

    exe_pkg::aluOpT    aluOp;
    exe_pkg::srcASelT  srcASel;
    exe_pkg::srcBSelT  srcBSel;
    exe_pkg::immFmtT   immFmt;
    exe_pkg::branchOpT branchOp;
    logic              decWriteEn;
    logic              decIllegal;
    logic [4:0]        decRdAddr;
    exe_pkg::xlenT     imm;
    exe_pkg::xlenT     opA;
    exe_pkg::xlenT     opB;
    exe_pkg::xlenT     aluResult;
    logic              aluZero;
    logic              taken;
    exe_pkg::xlenT     branchTarget;

    exeDecode decode (
        .instr    (instr),
        .aluOp    (aluOp),
        .srcASel  (srcASel),
        .srcBSel  (srcBSel),
        .immFmt   (immFmt),
        .branchOp (branchOp),
        .writeEn  (decWriteEn),
        .illegal  (decIllegal),
        .rdAddr   (decRdAddr)
    );

    immGen immediate (
        .instr  (instr),
        .immFmt (immFmt),
        .imm    (imm)
    );

    // ***********************************************************
    // operand selection.
    // ***********************************************************
    assign opA = (srcASel == exe_pkg::srcAPc) ? pc : rs1Data;

    always_comb begin
        case (srcBSel)
            exe_pkg::srcBImm:  opB = imm;
            exe_pkg::srcBFour: opB = exe_pkg::xlenT'(4); // link address offset.
            default:           opB = rs2Data;
        endcase
    end

    alu aluCore (
        .opA    (opA),
        .opB    (opB),
        .aluOp  (aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    branchUnit branch (
        .branchOp (branchOp),
        .zero     (aluZero),
        .less     (aluResult[0]), // slt and sltu leave the compare in bit 0.
        .pc       (pc),
        .rs1Data  (rs1Data),
        .imm      (imm),
        .taken    (taken),
        .target   (branchTarget)
    );

    // ***********************************************************
    // output register, one cycle after the input strobe.
    // ***********************************************************
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid    <= 1'b0;
            writeEn     <= 1'b0;
            branchTaken <= 1'b0;
            illegal     <= 1'b0;
        end else begin
            outValid    <= inValid;
            writeEn     <= inValid & decWriteEn;
            branchTaken <= inValid & taken;
            illegal     <= inValid & decIllegal;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin // idle cycles keep the last data.
            result <= aluResult;
            rdAddr <= decRdAddr;
            target <= branchTarget;
        end
    end

endmodule

//--- exeUnit_chk.sv
`timescale 1ns/1ns

module exeUnit_chk (
    input logic clk,
    input logic rstN,
    input logic outValid,
    input logic writeEn,
    input logic branchTaken,
    input logic illegal
);

    // ************************************************************
    // output register invariants.
    // ************************************************************
    resetIdle: assert property (@(posedge clk) !rstN |=> !outValid)
        else $error("outValid high while reset is held");

    writeNeedsValid: assert property (@(posedge clk) disable iff (!rstN) writeEn |-> outValid)
        else $error("writeEn high without outValid");

    takenNeedsValid: assert property (@(posedge clk) disable iff (!rstN)
                                      branchTaken |-> outValid)
        else $error("branchTaken high without outValid");

    // an illegal word must never reach the register file.
    illegalNoWrite: assert property (@(posedge clk) disable iff (!rstN) illegal |-> !writeEn)
        else $error("illegal and writeEn high together");

endmodule

bind exeUnit exeUnit_chk chk (
    .clk         (clk),
    .rstN        (rstN),
    .outValid    (outValid),
    .writeEn     (writeEn),
    .branchTaken (branchTaken),
    .illegal     (illegal)
);

//--- exeUnit_tb.sv
`timescale 1ns/1ns

module exeUnit_tb;

    localparam logic [6:0] opOp    = 7'b0110011;
    localparam logic [6:0] opImm   = 7'b0010011;
    localparam logic [6:0] opOp32  = 7'b0111011;
    localparam logic [6:0] opImm32 = 7'b0011011;
    localparam logic [6:0] opLui   = 7'b0110111;
    localparam logic [6:0] opAuipc = 7'b0010111;
    localparam logic [6:0] opJalr  = 7'b1100111;

    localparam logic [4:0] rdReg = 5'd3;

    localparam exe_pkg::xlenT pc0     = 64'h1000;
    localparam exe_pkg::xlenT allOnes = 64'hffffffffffffffff;
    localparam exe_pkg::xlenT minVal  = 64'h8000000000000000;
    localparam exe_pkg::xlenT maxVal  = 64'h7fffffffffffffff;
    localparam exe_pkg::xlenT wordMin = 64'hffffffff80000000;

    logic           clk;
    logic           rstN;
    logic           inValid;
    exe_pkg::instrT instr;
    exe_pkg::xlenT  pc;
    exe_pkg::xlenT  rs1Data;
    exe_pkg::xlenT  rs2Data;
    logic           outValid;
    exe_pkg::xlenT  result;
    logic [4:0]     rdAddr;
    logic           writeEn;
    logic           branchTaken;
    exe_pkg::xlenT  target;
    logic           illegal;
    integer         seed;

    // the stimulus table keeps its flags as {writeEn, taken, illegal}.
    exe_pkg::instrT instrQ[$];
    exe_pkg::xlenT  pcQ[$];
    exe_pkg::xlenT  aQ[$];
    exe_pkg::xlenT  bQ[$];
    exe_pkg::xlenT  resQ[$];
    exe_pkg::xlenT  tgtQ[$];
    logic [2:0]     flagQ[$];

    exeUnit UUT (.*);

    always #50 clk = ~clk;

    // ************************************************************
    // instruction encoders with rd fixed at rdReg, rs1 at 1 and rs2 at 2.
    // ************************************************************
    function automatic exe_pkg::instrT encR(logic [6:0] f7, logic [2:0] f3, logic [6:0] op);
        return {f7, 5'd2, 5'd1, f3, rdReg, op};
    endfunction

    function automatic exe_pkg::instrT encI(logic [11:0] imm, logic [2:0] f3, logic [6:0] op);
        return {imm, 5'd1, f3, rdReg, op};
    endfunction

    function automatic exe_pkg::instrT encB(logic [12:0] imm, logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic exe_pkg::instrT encU(logic [19:0] imm, logic [6:0] op);
        return {imm, rdReg, op};
    endfunction

    function automatic exe_pkg::instrT encJ(logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rdReg, 7'b1101111};
    endfunction

    // register-register reference model where word results sign-extend from bit 31.
    function automatic exe_pkg::xlenT refAlu(logic [2:0] f3, logic alt, logic word,
                                             exe_pkg::xlenT a, exe_pkg::xlenT b);
        logic [31:0]   w;
        exe_pkg::xlenT d;
        if (word) begin
            case (f3)
                3'd0: w = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
                3'd1: w = a[31:0] << b[4:0];
                default: begin
                    if (alt) begin
                        w = $signed(a[31:0]) >>> b[4:0];
                    end else begin
                        w = a[31:0] >> b[4:0];
                    end
                end
            endcase
            d = {{32{w[31]}}, w};
        end else begin
            case (f3)
                3'd0: d = alt ? a - b : a + b;
                3'd1: d = a << b[5:0];
                3'd2: d = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                3'd3: d = (a < b) ? 64'd1 : 64'd0;
                3'd4: d = a ^ b;
                3'd5: begin
                    if (alt) begin
                        d = $signed(a) >>> b[5:0];
                    end else begin
                        d = a >> b[5:0];
                    end
                end
                3'd6: d = a | b;
                default: d = a & b;
            endcase
        end
        return d;
    endfunction

    task automatic stopWithFailure();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compareXlen(string name, exe_pkg::xlenT exp, exe_pkg::xlenT act);
        if (act !== exp) begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            stopWithFailure();
        end
    endtask

    task automatic compareFlag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            stopWithFailure();
        end
    endtask

    task automatic compareAddr(string name, logic [4:0] exp, logic [4:0] act);
        if (act !== exp) begin
            $display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
            stopWithFailure();
        end
    endtask

    task automatic addRow(exe_pkg::instrT i, exe_pkg::xlenT p, exe_pkg::xlenT a,
                          exe_pkg::xlenT b, exe_pkg::xlenT res, exe_pkg::xlenT tgt,
                          logic [2:0] flags);
        instrQ.push_back(i);
        pcQ.push_back(p);
        aQ.push_back(a);
        bQ.push_back(b);
        resQ.push_back(res);
        tgtQ.push_back(tgt);
        flagQ.push_back(flags);
    endtask

    // pattern gives taken for the pairs {equal, -1 vs 1, 1 vs -1}.
    task automatic addBranchRows(logic [2:0] f3, logic [2:0] pattern);
        addRow(encB(13'h020, f3), pc0, 64'd3, 64'd3, 64'd0, 64'h1020, {1'b0, pattern[2], 1'b0});
        addRow(encB(13'h020, f3), pc0, allOnes, 64'd1, 64'd0, 64'h1020, {1'b0, pattern[1], 1'b0});
        addRow(encB(13'h020, f3), pc0, 64'd1, allOnes, 64'd0, 64'h1020, {1'b0, pattern[0], 1'b0});
    endtask

    task automatic buildTable();
        addRow(encR(7'h00, 3'd0, opOp), pc0, 64'd5, 64'd7, 64'd12, 64'd0, 3'b100);
        addRow(encR(7'h00, 3'd0, opOp), pc0, allOnes, 64'd1, 64'd0, 64'd0, 3'b100);
        addRow(encR(7'h20, 3'd0, opOp), pc0, 64'd0, 64'd1, allOnes, 64'd0, 3'b100);
        addRow(encR(7'h20, 3'd0, opOp), pc0, minVal, 64'd1, maxVal, 64'd0, 3'b100);
        addRow(encR(7'h00, 3'd4, opOp), pc0, 64'hf0f0, 64'hff00, 64'h0ff0, 64'd0, 3'b100);
        addRow(encR(7'h00, 3'd6, opOp), pc0, 64'hf0f0, 64'h0f00, 64'hfff0, 64'd0, 3'b100);
        addRow(encR(7'h00, 3'd7, opOp), pc0, 64'hf0f0, 64'hff00, 64'hf000, 64'd0, 3'b100);
        addRow(encI(12'hfff, 3'd0, opImm), pc0, 64'd100, 64'd0, 64'd99, 64'd0, 3'b100);
        addRow(encI(12'hff0, 3'd7, opImm), pc0, 64'h1234, 64'd0, 64'h1230, 64'd0, 3'b100);
        addRow(encR(7'h00, 3'd2, opOp), pc0, allOnes, 64'd1, 64'd1, 64'd0, 3'b100);
        addRow(encR(7'h00, 3'd3, opOp), pc0, allOnes, 64'd1, 64'd0, 64'd0, 3'b100);
        addRow(encR(7'h00, 3'd2, opOp), pc0, 64'd1, allOnes, 64'd0, 64'd0, 3'b100);
        addRow(encR(7'h00, 3'd3, opOp), pc0, 64'd1, allOnes, 64'd1, 64'd0, 3'b100);
        addRow(encI(12'hfff, 3'd3, opImm), pc0, 64'd0, 64'd0, 64'd1, 64'd0, 3'b100);
        addRow(encR(7'h00, 3'd1, opOp), pc0, 64'd1, 64'd63, minVal, 64'd0, 3'b100);
        addRow(encR(7'h00, 3'd5, opOp), pc0, minVal, 64'd63, 64'd1, 64'd0, 3'b100);
        addRow(encR(7'h20, 3'd5, opOp), pc0, minVal, 64'd4, 64'hf800000000000000, 64'd0,
               3'b100);
        addRow(encI(12'h43f, 3'd5, opImm), pc0, minVal, 64'd0, allOnes, 64'd0, 3'b100);
        addRow(encI(12'h004, 3'd1, opImm), pc0, 64'd1, 64'd0, 64'h10, 64'd0, 3'b100);
        // word forms ignore the upper operand bits.
        addRow(encR(7'h00, 3'd0, opOp32), pc0, 64'h57fffffff, 64'd1, wordMin, 64'd0, 3'b100);
        addRow(encR(7'h20, 3'd0, opOp32), pc0, 64'h1200000000, 64'd1, allOnes, 64'd0, 3'b100);
        addRow(encR(7'h00, 3'd1, opOp32), pc0, 64'h300000001, 64'h3f, wordMin, 64'd0, 3'b100);
        addRow(encR(7'h00, 3'd5, opOp32), pc0, wordMin, 64'd4, 64'h08000000, 64'd0, 3'b100);
        addRow(encR(7'h20, 3'd5, opOp32), pc0, 64'h80000000, 64'd4, 64'hfffffffff8000000,
               64'd0, 3'b100);
        addRow(encI(12'h001, 3'd0, opImm32), pc0, 64'h7fffffff, 64'd0, wordMin, 64'd0, 3'b100);
        addRow(encU(20'h80000, opLui), pc0, 64'd0, 64'd0, wordMin, 64'd0, 3'b100);
        addRow(encU(20'h00001, opAuipc), pc0, 64'd0, 64'd0, 64'h2000, 64'd0, 3'b100);
        addRow(encU(20'hfffff, opAuipc), 64'h3000, 64'd0, 64'd0, 64'h2000, 64'd0, 3'b100);
        addRow(encJ(21'h000100), pc0, 64'd0, 64'd0, 64'h1004, 64'h1100, 3'b110);
        addRow(encJ(21'h1ffff8), pc0, 64'd0, 64'd0, 64'h1004, 64'h0ff8, 3'b110);
        addRow(encI(12'h010, 3'd0, opJalr), pc0, 64'h2001, 64'd0, 64'h1004, 64'h2010, 3'b110);
        addRow(encI(12'hfff, 3'd0, opJalr), pc0, 64'h2000, 64'd0, 64'h1004, 64'h1ffe, 3'b110);
        addBranchRows(3'd0, 3'b100);
        addBranchRows(3'd1, 3'b011);
        addBranchRows(3'd4, 3'b010);
        addBranchRows(3'd5, 3'b101);
        addBranchRows(3'd6, 3'b001);
        addBranchRows(3'd7, 3'b110);
        addRow(32'h00000000, pc0, 64'd0, 64'd0, 64'd0, 64'd0, 3'b001);
        addRow(encR(7'h01, 3'd0, opOp), pc0, 64'd2, 64'd3, 64'd0, 64'd0, 3'b001);
        addRow(encR(7'h00, 3'd2, opOp32), pc0, 64'd2, 64'd3, 64'd0, 64'd0, 3'b001);
        addRow(encB(13'h020, 3'd2), pc0, 64'd3, 64'd3, 64'd0, 64'd0, 3'b001);
    endtask

    task automatic waitResult();
        int cycles;
        cycles = 0;
        @(negedge clk);
        inValid = 1'b0;
        while (!outValid) begin
            if (cycles == 8) begin
                $display("timeout while waiting for outValid after an input");
                stopWithFailure();
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic applyRow(int k);
        logic [2:0] f;
        logic       isBranch;
        @(negedge clk);
        instr   = instrQ[k];
        pc      = pcQ[k];
        rs1Data = aQ[k];
        rs2Data = bQ[k];
        inValid = 1'b1;
        waitResult();
        f        = flagQ[k];
        isBranch = (instrQ[k][6:0] == 7'b1100011);
        compareFlag("writeEn", f[2], writeEn);
        compareFlag("branchTaken", f[1], branchTaken);
        compareFlag("illegal", f[0], illegal);
        if (f[2]) begin
            compareXlen("result", resQ[k], result);
            compareAddr("rdAddr", rdReg, rdAddr);
        end
        if ((f[1] || isBranch) && !f[0]) begin
            compareXlen("target", tgtQ[k], target);
        end
    endtask

    // ************************************************************
    // random back-to-back register-register traffic.
    // ************************************************************
    task automatic runRandom(int count);
        exe_pkg::xlenT expRes;
        exe_pkg::xlenT a;
        exe_pkg::xlenT b;
        logic [31:0]   r;
        logic [2:0]    f3;
        logic          alt;
        logic          word;
        expRes = '0;
        for (int n = 0; n <= count; n++) begin
            @(negedge clk);
            if (n > 0) begin // each result is due exactly one cycle later.
                compareFlag("outValid", 1'b1, outValid);
                compareFlag("writeEn", 1'b1, writeEn);
                compareFlag("illegal", 1'b0, illegal);
                compareXlen("result", expRes, result);
                compareAddr("rdAddr", rdReg, rdAddr);
            end
            if (n == count) begin
                inValid = 1'b0;
            end else begin
                r    = $random(seed);
                word = r[6];
                f3   = r[4:2];
                if (word) begin
                    f3 = (r[3:2] == 2'd0) ? 3'd0 : ((r[3:2] == 2'd1) ? 3'd1 : 3'd5);
                end
                alt     = r[5] && (f3 == 3'd0 || f3 == 3'd5);
                a       = {$random(seed), $random(seed)};
                b       = {$random(seed), $random(seed)};
                instr   = encR(alt ? 7'h20 : 7'h00, f3, word ? opOp32 : opOp);
                pc      = pc0;
                rs1Data = a;
                rs2Data = b;
                inValid = 1'b1;
                expRes  = refAlu(f3, alt, word, a, b);
            end
        end
        @(negedge clk);
        compareFlag("outValid", 1'b0, outValid);
        compareFlag("writeEn", 1'b0, writeEn);
        compareFlag("branchTaken", 1'b0, branchTaken);
        compareXlen("result", expRes, result); // data holds over an idle cycle.
    endtask

    initial begin
        clk     = 1'b0;
        rstN    = 1'b0;
        inValid = 1'b0;
        instr   = '0;
        pc      = '0;
        rs1Data = '0;
        rs2Data = '0;
        seed    = 57;
        buildTable();
        repeat (16) @(negedge clk);
        compareFlag("outValid", 1'b0, outValid);
        compareFlag("writeEn", 1'b0, writeEn);
        compareFlag("branchTaken", 1'b0, branchTaken);
        compareFlag("illegal", 1'b0, illegal);
        rstN = 1'b1;
        @(negedge clk);
        compareFlag("outValid", 1'b0, outValid);
        for (int k = 0; k < instrQ.size(); k++) begin
            applyRow(k);
        end
        runRandom(200);
        $display("Test passed");
        $finish;
    end

endmodule

//--- build.f
+incdir+.
exe_pkg.sv
exeDecode.sv
immGen.sv
aluAdder.sv
alu.sv
branchUnit.sv
exeUnit.sv
exeUnit_chk.sv
exeUnit_tb.sv

//--- Bender.yml
package:
  name: exe_unit

export_include_dirs:
  - .

sources:
  - exe_pkg.sv
  - exeDecode.sv
  - immGen.sv
  - aluAdder.sv
  - alu.sv
  - branchUnit.sv
  - exeUnit.sv
  - target: test
    files:
      - exeUnit_chk.sv
      - exeUnit_tb.sv
